/* all.f */
+incdir+tb
rtl/jbus_pkg.sv
rtl/trace_pkg.sv
rtl/jbus_ram.sv
rtl/jbus_trace_recorder.sv
rtl/trace_fifo.sv
rtl/trace_ctrl_regs.sv
rtl/jbus_trace_top.sv
tb/tb_jbus_trace.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_jbus_trace
FILELIST  ?= all.f
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf obj_dir

/* tb/trace_model.svh */
// ==========================================================================
// Reference model for the traced JBUS slave, included into the testbench
// Mirrors the RAM, the trace filters and the records the FIFO should hold
// ==========================================================================

`ifndef trace_model_svh
`define trace_model_svh

logic [jbus_pkg::data_width-1:0] model_mem [2**jbus_pkg::addr_width];
trace_pkg::trace_rec_t           expect_q [$];	// records in the order they should pop
int                              model_drops;
bit                              model_reads;
bit                              model_writes;

// the enable bit gates both filter bits
function automatic void set_filters(input logic [2:0] ctrl);
	model_reads  = ctrl[trace_pkg::ctrl_enable] & ctrl[trace_pkg::ctrl_reads];
	model_writes = ctrl[trace_pkg::ctrl_enable] & ctrl[trace_pkg::ctrl_writes];
endfunction

function automatic void append_record(input trace_pkg::trace_rec_t rec);
	if (expect_q.size() < trace_pkg::trace_depth) begin
		expect_q.push_back(rec);
	end else if (model_drops < 16'hffff) begin
		model_drops++;	// a full FIFO loses the record, the count saturates
	end
endfunction

// gives the word a read returns and applies the enabled lanes of a write
function automatic void apply_access(input jbus_pkg::jbus_req_t req,
		output logic [jbus_pkg::data_width-1:0] rd);
	trace_pkg::trace_rec_t rec;
	rd = model_mem[req.addr];
	if (req.we) begin
		for (int i = 0; i < jbus_pkg::sel_width; i++) begin
			if (req.sel[i]) begin
				model_mem[req.addr][8*i +: 8] = req.wdata[8*i +: 8];
			end
		end
	end
	rec = '{we: req.we, sel: req.sel, addr: req.addr, data: req.we ? req.wdata : rd, stamp: '0};
	if (req.we ? model_writes : model_reads) begin
		append_record(rec);
	end
endfunction

`endif

/* tb/tb_jbus_trace.sv */
// ==========================================================================
// Random-stimulus testbench for the traced JBUS slave
// Drives both ports on the falling edge and checks against the included model
// ==========================================================================

module tb_jbus_trace;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [11:0] window_base = 12'h6c0;	// random accesses stay in 16 words
	localparam int n_random = 40;
	localparam int n_traced = 12;
	localparam int n_filter = 10;
	localparam int n_fill   = 20;
	localparam int n_burst  = 16;
	localparam int n_access = 16 + n_random + n_traced + 3 * n_filter + n_fill + n_burst;
	// worst case per access is a wait write, three wait states and popping its record
	localparam int access_cycles = 14;
	localparam int watchdog_ns   = (n_access * access_cycles + 400) * 100;

	logic                            clk;
	logic                            reset;
	jbus_pkg::jbus_req_t             jbus_req;
	logic                            jbus_ready;
	logic [jbus_pkg::data_width-1:0] jbus_rdata;
	jbus_pkg::cfg_req_t              cfg;
	logic [jbus_pkg::data_width-1:0] cfg_rdata;

	logic                            acc_seen;	// bus state at the last rising edge
	logic                            rdy_seen;
	logic [jbus_pkg::data_width-1:0] data_seen;
	logic [1:0]                      exp_wait;	// wait states the RAM should insert

	int    errors;
	int    errors_at_start;
	int    tests_run;
	int    tests_failed;
	string test_name;

	`include "trace_model.svh"

	jbus_trace_top u_jbus_trace_top (
		.clk(clk), .reset(reset), .jbus_req(jbus_req), .jbus_ready(jbus_ready),
		.jbus_rdata(jbus_rdata), .cfg(cfg), .cfg_rdata(cfg_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		acc_seen  <= jbus_req.en & jbus_req.valid & jbus_ready;
		rdy_seen  <= jbus_ready;
		data_seen <= jbus_rdata;
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, the DUT stopped responding", watchdog_ns);
		$display("Errors found");
		$finish;
	end

	task automatic compare_data(input string name, input logic [jbus_pkg::data_width-1:0] got,
			input logic [jbus_pkg::data_width-1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// the model cannot know stamps, their order is checked while draining
	task automatic compare_rec(input string name, input trace_pkg::trace_rec_t got,
			input trace_pkg::trace_rec_t exp);
		if ({got.we, got.sel, got.addr, got.data} !== {exp.we, exp.sel, exp.addr, exp.data}) begin
			$display("Fail at %0t: %s got we %b sel %h addr %h data %h", $time, name,
				got.we, got.sel, got.addr, got.data);
			$display("    expected we %b sel %h addr %h data %h", exp.we, exp.sel, exp.addr, exp.data);
			errors++;
		end
	endtask

	task automatic compare_count(input string name,
			input logic [trace_pkg::count_width-1:0] got_count,
			input logic [trace_pkg::count_width-1:0] exp_count,
			input logic [trace_pkg::drop_width-1:0]  got_drops,
			input logic [trace_pkg::drop_width-1:0]  exp_drops);
		if (got_count !== exp_count) begin
			$display("Fail at %0t: %s fill count got %0d expected %0d", $time, name,
				got_count, exp_count);
			errors++;
		end
		if (got_drops !== exp_drops) begin
			$display("Fail at %0t: %s drop count got %0d expected %0d", $time, name,
				got_drops, exp_drops);
			errors++;
		end
	endtask

	// stall cycles seen on ready against the programmed wait count
	task automatic compare_wait(input string name, input int got, input logic [1:0] exp);
		if (got != int'(exp)) begin
			$display("Fail at %0t: %s got %0d wait cycles expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// every register access takes two cycles so a pop lands before the next read
	task automatic cfg_read(input logic [jbus_pkg::cfg_addr_width-1:0] word_addr,
			output logic [jbus_pkg::data_width-1:0] data);
		cfg = '{en: 1'b1, addr: word_addr, wdata: '0, we: 1'b0, valid: 1'b1};
		@(negedge clk);
		cfg = '0;
		@(negedge clk);
		data = cfg_rdata;
	endtask

	task automatic cfg_write(input logic [jbus_pkg::cfg_addr_width-1:0] word_addr,
			input logic [jbus_pkg::data_width-1:0] data);
		cfg = '{en: 1'b1, addr: word_addr, wdata: data, we: 1'b1, valid: 1'b1};
		@(negedge clk);
		cfg = '0;
		@(negedge clk);	// the drop clear pulse is one cycle late
		if (word_addr == trace_pkg::reg_ctrl) set_filters(data[2:0]);
		if (word_addr == trace_pkg::reg_wait) exp_wait = data[1:0];
		if (word_addr == trace_pkg::reg_status) model_drops = 0;
	endtask

	// holds the request until ready lets it through, returns in the next cycle
	task automatic issue(input jbus_pkg::jbus_req_t r);
		int n;
		n = 0;
		jbus_req = r;
		do begin
			@(negedge clk);
			n++;
		end while (!acc_seen && n < 8);
		if (!acc_seen) begin
			$display("access to %h was not accepted, ready stayed low for 8 cycles", r.addr);
			errors++;
		end else begin
			compare_wait("jbus_ready", n - 1, exp_wait);
		end
	endtask

	// read data belongs to the first ready cycle after acceptance
	task automatic bus_access(input jbus_pkg::jbus_req_t r,
			output logic [jbus_pkg::data_width-1:0] data);
		issue(r);
		jbus_req = '0;
		do begin
			@(negedge clk);
		end while (!rdy_seen);
		data = data_seen;
	endtask

	function automatic jbus_pkg::jbus_req_t random_req();
		jbus_pkg::jbus_req_t r;
		r.en        = 1'b1;
		r.valid     = 1'b1;
		r.we        = 1'($urandom);
		r.addr      = window_base;
		r.addr[3:0] = 4'($urandom);
		r.wdata     = $urandom;
		r.sel       = 4'($urandom);
		return r;
	endfunction

	task automatic random_ops(input int n);
		jbus_pkg::jbus_req_t             r;
		logic [jbus_pkg::data_width-1:0] got;
		logic [jbus_pkg::data_width-1:0] exp;
		for (int i = 0; i < n; i++) begin
			cfg_write(trace_pkg::reg_wait, $urandom % 4);
			r = random_req();
			apply_access(r, exp);
			bus_access(r, got);
			if (!r.we) compare_data("jbus_rdata", got, exp);
		end
	endtask

	task automatic check_status(input int exp_count, input int exp_drops);
		logic [jbus_pkg::data_width-1:0] word;
		cfg_read(trace_pkg::reg_status, word);
		compare_count("reg_status", word[4:0], exp_count, word[23:8], exp_drops);
	endtask

	task automatic pop_record(output trace_pkg::trace_rec_t rec);
		logic [jbus_pkg::data_width-1:0] lo;
		logic [jbus_pkg::data_width-1:0] data;
		logic [jbus_pkg::data_width-1:0] hi;
		cfg_read(trace_pkg::reg_rec_lo, lo);
		cfg_read(trace_pkg::reg_rec_data, data);
		cfg_read(trace_pkg::reg_rec_hi, hi);	// this read pops the head
		rec = '{we: lo[16], sel: lo[15:12], addr: lo[11:0], data: data, stamp: hi[15:0]};
	endtask

	task automatic drain_and_check();
		trace_pkg::trace_rec_t got;
		logic [15:0]           last_stamp;
		int                    n;
		check_status(expect_q.size(), model_drops);
		n = expect_q.size();
		for (int i = 0; i < n; i++) begin
			pop_record(got);
			compare_rec("trace record", got, expect_q.pop_front());
			if (i > 0 && got.stamp <= last_stamp) begin
				$display("stamp %0d of record %0d does not follow stamp %0d", got.stamp, i, last_stamp);
				errors++;
			end
			last_stamp = got.stamp;
		end
		check_status(0, model_drops);
	endtask

	task automatic start_test(input string name);
		test_name       = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %0d %s: ok", tests_run, test_name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d mismatches", tests_run, test_name, errors - errors_at_start);
		end
	endtask

	initial begin
		logic [jbus_pkg::data_width-1:0] word;
		jbus_pkg::jbus_req_t             r;
		logic [2:0]                      modes [3];
		void'($urandom(32'h113b69fe));
		modes        = '{3'b011, 3'b101, 3'b110};	// reads only, writes only, enable off
		reset        = 1'b1;
		jbus_req     = '0;
		cfg          = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		model_drops  = 0;
		exp_wait     = 2'd0;
		set_filters(3'b000);
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		start_test("reset values");
		for (int a = 0; a <= 5; a++) begin
			cfg_read(3'(a), word);
			compare_data($sformatf("cfg word %0d", a), word, '0);
		end
		end_test();

		start_test("random memory access");
		for (int i = 0; i < 16; i++) begin	// untraced fill so no read sees unknown data
			r = '{en: 1'b1, addr: window_base + 12'(i), wdata: $urandom, we: 1'b1, sel: 4'hf,
				valid: 1'b1};
			apply_access(r, word);
			bus_access(r, word);
		end
		random_ops(n_random);
		drain_and_check();
		end_test();

		start_test("full trace order");
		cfg_write(trace_pkg::reg_ctrl, 3'b111);
		random_ops(n_traced);
		drain_and_check();
		end_test();

		start_test("trace filters");
		for (int m = 0; m < 3; m++) begin
			cfg_write(trace_pkg::reg_ctrl, modes[m]);
			random_ops(n_filter);
			drain_and_check();
		end
		end_test();

		start_test("overflow and drop clear");
		cfg_write(trace_pkg::reg_ctrl, 3'b111);
		random_ops(n_fill);
		cfg_read(trace_pkg::reg_status, word);
		compare_count("reg_status", word[4:0], 16, word[23:8], 4);
		cfg_write(trace_pkg::reg_status, '0);
		drain_and_check();
		end_test();

		start_test("back-to-back accesses");
		cfg_write(trace_pkg::reg_wait, '0);
		for (int i = 0; i < n_burst; i++) begin
			r = random_req();
			apply_access(r, word);
			issue(r);
		end
		jbus_req = '0;
		repeat (2) @(negedge clk);
		drain_and_check();
		end_test();

		$display("%0d tests, %0d failed, %0d failed checks", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* rtl/jbus_trace_top.sv */
// ==========================================================================
// Traced JBUS slave: RAM, bus recorder, trace FIFO and register block
// The master drives jbus_req, software uses the cfg port
// ==========================================================================

module jbus_trace_top (
	input  logic                            clk,
	input  logic                            reset,
	input  jbus_pkg::jbus_req_t             jbus_req,
	output logic                            jbus_ready,
	output logic [jbus_pkg::data_width-1:0] jbus_rdata,
	input  jbus_pkg::cfg_req_t              cfg,
	output logic [jbus_pkg::data_width-1:0] cfg_rdata
);

	logic                              trace_reads;
	logic                              trace_writes;
	logic [1:0]                        wait_cycles;
	logic                              push;
	trace_pkg::trace_rec_t             rec;
	logic                              pop;
	logic                              clear_drops;
	trace_pkg::trace_rec_t             rec_out;
	logic [trace_pkg::count_width-1:0] count;
	logic [trace_pkg::drop_width-1:0]  drops;

	jbus_ram u_jbus_ram (
		.clk(clk), .reset(reset), .req(jbus_req), .wait_cycles(wait_cycles),
		.ready(jbus_ready), .rdata(jbus_rdata)
	);

	jbus_trace_recorder u_jbus_trace_recorder (
		.clk(clk), .reset(reset), .req(jbus_req), .ready(jbus_ready), .rdata(jbus_rdata),
		.trace_reads(trace_reads), .trace_writes(trace_writes), .push(push), .rec(rec)
	);

	trace_fifo u_trace_fifo (
		.clk(clk), .reset(reset), .push(push), .rec_in(rec), .pop(pop), .rec_out(rec_out),
		.count(count), .drops(drops), .clear_drops(clear_drops)
	);

	trace_ctrl_regs u_trace_ctrl_regs (
		.clk(clk), .reset(reset), .cfg(cfg), .cfg_rdata(cfg_rdata), .rec_out(rec_out),
		.count(count), .drops(drops), .trace_reads(trace_reads), .trace_writes(trace_writes),
		.wait_cycles(wait_cycles), .pop(pop), .clear_drops(clear_drops)
	);

endmodule

/* rtl/trace_ctrl_regs.sv */
// ==========================================================================
// Configuration and trace readout registers on the always-ready port
// Read data follows acceptance by one cycle, a stamp read pops the record
// ==========================================================================

module trace_ctrl_regs (
	input  logic                              clk,
	input  logic                              reset,
	input  jbus_pkg::cfg_req_t                cfg,
	output logic [jbus_pkg::data_width-1:0]   cfg_rdata,
	input  trace_pkg::trace_rec_t             rec_out,
	input  logic [trace_pkg::count_width-1:0] count,
	input  logic [trace_pkg::drop_width-1:0]  drops,
	output logic                              trace_reads,
	output logic                              trace_writes,
	output logic [1:0]                        wait_cycles,
	output logic                              pop,
	output logic                              clear_drops
);

	logic [2:0]                      ctrl;	// enable, trace reads, trace writes
	logic [1:0]                      wait_cfg;
	logic                            rd_acc;
	logic                            wr_acc;
	logic [jbus_pkg::data_width-1:0] rd_word;

	assign rd_acc = cfg.en & cfg.valid & !cfg.we;
	assign wr_acc = cfg.en & cfg.valid & cfg.we;

	// the filters only count when the global enable is set
	assign trace_reads  = ctrl[trace_pkg::ctrl_enable] & ctrl[trace_pkg::ctrl_reads];
	assign trace_writes = ctrl[trace_pkg::ctrl_enable] & ctrl[trace_pkg::ctrl_writes];
	assign wait_cycles  = wait_cfg;

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl     <= '0;
			wait_cfg <= '0;
		end else if (wr_acc) begin
			case (cfg.addr)
				trace_pkg::reg_ctrl: ctrl     <= cfg.wdata[2:0];
				trace_pkg::reg_wait: wait_cfg <= cfg.wdata[1:0];
				default:             ;	// other words are read-only
			endcase
		end
	end

	always_comb begin
		rd_word = '0;
		case (cfg.addr)
			trace_pkg::reg_ctrl: rd_word[2:0] = ctrl;
			trace_pkg::reg_wait: rd_word[1:0] = wait_cfg;
			trace_pkg::reg_status: begin
				rd_word[trace_pkg::count_width-1:0] = count;
				rd_word[8 +: trace_pkg::drop_width] = drops;
			end
			trace_pkg::reg_rec_lo: begin
				rd_word[jbus_pkg::addr_width-1:0]                   = rec_out.addr;
				rd_word[jbus_pkg::addr_width +: jbus_pkg::sel_width] = rec_out.sel;
				rd_word[jbus_pkg::addr_width + jbus_pkg::sel_width] = rec_out.we;
			end
			trace_pkg::reg_rec_data: rd_word = rec_out.data;
			trace_pkg::reg_rec_hi:   rd_word[trace_pkg::stamp_width-1:0] = rec_out.stamp;
			default:                 rd_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rd_acc) begin
			cfg_rdata <= rd_word;
		end
	end

	// both pulses come one cycle late so the read above still sees the record
	always_ff @(posedge clk) begin
		if (reset) begin
			pop         <= 1'b0;
			clear_drops <= 1'b0;
		end else begin
			pop         <= rd_acc && cfg.addr == trace_pkg::reg_rec_hi && count != '0;
			clear_drops <= wr_acc && cfg.addr == trace_pkg::reg_status;
		end
	end

	// only pops can lower the count, so it is still nonzero a cycle later
	pop_not_empty: assert property (
		@(posedge clk) disable iff (reset)
		pop |-> count != '0
	);

endmodule

/* rtl/trace_fifo.sv */
// ==========================================================================
// Circular buffer of trace records with a fill count and a drop counter
// Pushes into a full buffer are lost and counted, the counter saturates
// ==========================================================================

module trace_fifo (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              push,
	input  trace_pkg::trace_rec_t             rec_in,
	input  logic                              pop,
	output trace_pkg::trace_rec_t             rec_out,
	output logic [trace_pkg::count_width-1:0] count,
	output logic [trace_pkg::drop_width-1:0]  drops,
	input  logic                              clear_drops
);

	trace_pkg::trace_rec_t mem [trace_pkg::trace_depth];

	logic [$clog2(trace_pkg::trace_depth)-1:0] wr_ptr;
	logic [$clog2(trace_pkg::trace_depth)-1:0] rd_ptr;
	logic full;
	logic empty;
	logic do_push;
	logic do_pop;

	assign full    = (count == trace_pkg::trace_depth);
	assign empty   = (count == '0);
	assign do_push = push & !full;
	assign do_pop  = pop & !empty;

	assign rec_out = empty ? '0 : mem[rd_ptr];	// software sees zero when nothing is held

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= rec_in;
		end
	end

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clear_drops) begin
			drops <= '0;
		end else if (push && full && drops != '1) begin
			drops <= drops + 1'b1;
		end
	end

	count_bound: assert property (
		@(posedge clk) disable iff (reset)
		count <= trace_pkg::trace_depth
	);

endmodule

/* rtl/jbus_trace_recorder.sv */
// ==========================================================================
// Passive JBUS monitor that turns accepted accesses into timestamped records
// Write records leave one cycle after acceptance, read records in the cycle
// where the read data is sampled
// ==========================================================================

module jbus_trace_recorder (
	input  logic                            clk,
	input  logic                            reset,
	input  jbus_pkg::jbus_req_t             req,
	input  logic                            ready,
	input  logic [jbus_pkg::data_width-1:0] rdata,
	input  logic                            trace_reads,
	input  logic                            trace_writes,
	output logic                            push,
	output trace_pkg::trace_rec_t           rec
);

	logic [trace_pkg::stamp_width-1:0] stamp;	// free-running cycle count

	logic                  rd_acc;
	logic                  wr_acc;
	logic                  rd_push;
	logic                  read_busy;	// a traced read waits for its data
	trace_pkg::trace_rec_t read_rec;
	logic                  wr_pend;	// a write record waits to be pushed
	trace_pkg::trace_rec_t wr_rec;

	assign rd_acc  = req.en & req.valid & ready & !req.we;
	assign wr_acc  = req.en & req.valid & ready & req.we;
	assign rd_push = read_busy & ready;	// first ready cycle after the read

	always_ff @(posedge clk) begin
		if (reset) begin
			stamp <= '0;
		end else begin
			stamp <= stamp + 1'b1;
		end
	end

	// same bookkeeping as the reference read_busy, with the filter applied
	// at acceptance time
	always_ff @(posedge clk) begin
		if (reset) begin
			read_busy <= 1'b0;
		end else if (rd_acc) begin
			read_busy <= trace_reads;
		end else if (ready) begin
			read_busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_acc) begin
			read_rec <= '{we: 1'b0, sel: req.sel, addr: req.addr, data: '0, stamp: stamp};
		end
	end

	// a read push takes the cycle, the write record then stays one more cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_pend <= 1'b0;
		end else if (wr_acc && trace_writes) begin
			wr_pend <= 1'b1;
		end else if (!rd_push) begin
			wr_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_acc && trace_writes) begin
			wr_rec <= '{we: 1'b1, sel: req.sel, addr: req.addr, data: req.wdata, stamp: stamp};
		end
	end

	always_comb begin
		push = rd_push | wr_pend;
		if (rd_push) begin
			rec      = read_rec;
			rec.data = rdata;	// data arrives only now
		end else begin
			rec = wr_rec;
		end
	end

	// a write is accepted only while ready is high, which retires any pending
	// read in that cycle, so at most one kind of record waits for the push
	one_record_kind: assert property (
		@(posedge clk) disable iff (reset)
		!(rd_push && wr_pend)
	);

endmodule

/* rtl/jbus_ram.sv */
// ==========================================================================
// Word-addressed JBUS slave memory with a programmable number of wait states
// Read data is registered on acceptance and held until the next read
// ==========================================================================

module jbus_ram (
	input  logic                            clk,
	input  logic                            reset,
	input  jbus_pkg::jbus_req_t             req,
	input  logic [1:0]                      wait_cycles,
	output logic                            ready,
	output logic [jbus_pkg::data_width-1:0] rdata
);

	logic [jbus_pkg::data_width-1:0] mem [2**jbus_pkg::addr_width];

	logic       access;
	logic       accept;
	logic       started;	// the pending access has already been seen once
	logic [1:0] wait_cnt;

	assign access = req.en & req.valid;

	// a fresh access drops ready at once unless no wait states are set,
	// after that ready follows the down-counter
	assign ready  = started ? (wait_cnt == 2'd0) : !(access && wait_cycles != 2'd0);
	assign accept = access & ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			started  <= 1'b0;
			wait_cnt <= 2'd0;
		end else if (accept) begin
			started <= 1'b0;
		end else if (access && !started) begin
			started  <= 1'b1;
			wait_cnt <= wait_cycles - 2'd1;	// the first wait cycle is the current one
		end else if (wait_cnt != 2'd0) begin
			wait_cnt <= wait_cnt - 2'd1;
		end
	end

	// byte lanes are written only where sel is set
	always_ff @(posedge clk) begin
		if (accept && req.we) begin
			for (int i = 0; i < jbus_pkg::sel_width; i++) begin
				if (req.sel[i]) begin
					mem[req.addr][8*i +: 8] <= req.wdata[8*i +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rdata <= '0;
		end else if (accept && !req.we) begin
			rdata <= mem[req.addr];
		end
	end

	// the master may sample rdata in any later ready cycle, so it must not
	// move underneath a stalled access
	rdata_stable_in_wait: assert property (
		@(posedge clk) disable iff (reset)
		!ready |=> $stable(rdata)
	);

endmodule

/* rtl/trace_pkg.sv */
// ==========================================================================
// Trace record format, trace FIFO sizing and the configuration register map
// ==========================================================================

package trace_pkg;

	localparam int stamp_width = 16;
	localparam int trace_depth = 16;	// records held in the trace FIFO
	localparam int count_width = 5;	// fill count, wide enough to show a full FIFO
	localparam int drop_width  = 16;

	// one bus access as the recorder saw it
	typedef struct packed {
		logic                            we;
		logic [jbus_pkg::sel_width-1:0]  sel;
		logic [jbus_pkg::addr_width-1:0] addr;
		logic [jbus_pkg::data_width-1:0] data;
		logic [stamp_width-1:0]          stamp;
	} trace_rec_t;

	// register word addresses on the configuration port
	localparam logic [jbus_pkg::cfg_addr_width-1:0] reg_ctrl     = 3'd0;
	localparam logic [jbus_pkg::cfg_addr_width-1:0] reg_wait     = 3'd1;
	localparam logic [jbus_pkg::cfg_addr_width-1:0] reg_status   = 3'd2;
	localparam logic [jbus_pkg::cfg_addr_width-1:0] reg_rec_lo   = 3'd3;
	localparam logic [jbus_pkg::cfg_addr_width-1:0] reg_rec_data = 3'd4;
	localparam logic [jbus_pkg::cfg_addr_width-1:0] reg_rec_hi   = 3'd5;

	// bit positions inside reg_ctrl
	localparam int ctrl_enable = 0;
	localparam int ctrl_reads  = 1;
	localparam int ctrl_writes = 2;

endpackage

/* rtl/jbus_pkg.sv */
// ==========================================================================
// JBUS and configuration port definitions shared by the trace subsystem
// The master-driven half of each bus travels as one packed request struct
// ==========================================================================

package jbus_pkg;

	localparam int addr_width = 12;	// word address on the JBUS port
	localparam int data_width = 32;
	localparam int sel_width  = 4;	// one select bit per byte lane

	localparam int cfg_addr_width = 3;	// word address on the configuration port

	// master-driven JBUS signals, ready and rdata come back from the slave
	typedef struct packed {
		logic                  en;
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] wdata;
		logic                  we;
		logic [sel_width-1:0]  sel;
		logic                  valid;
	} jbus_req_t;

	// the configuration port has no byte lanes and is always ready
	typedef struct packed {
		logic                      en;
		logic [cfg_addr_width-1:0] addr;
		logic [data_width-1:0]     wdata;
		logic                      we;
		logic                      valid;
	} cfg_req_t;

endpackage
